//--- include/bist_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bist defaults
// pattern depths for each test phase
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef bist_defs_svh
`define bist_defs_svh

`define bist_mbist_depth 8   // background patterns
`define bist_sa_depth 12     // stuck-at patterns
`define bist_td_depth 18     // transition-delay patterns

`endif

//--- source/bist_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bist package
// widths, vector types, fsm states and control structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bist_pkg;

    localparam int array_size = 8;
    localparam int weight_w = 8;
    localparam int act_w = 8;
    localparam int psum_w = weight_w + act_w + $clog2(array_size);   // 19 bits
    localparam int addr_w = $clog2(array_size);
    localparam int pat_w = 5;    // covers the 18 td patterns
    localparam int pe_w = 2;

    typedef logic [weight_w-1:0] weight_t;
    typedef logic [act_w-1:0] act_t;
    typedef logic [psum_w-1:0] psum_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [pat_w-1:0] pat_idx_t;
    typedef logic [pe_w-1:0] pe_sel_t;
    typedef logic [1:0] phase_t;

    typedef psum_t [array_size-1:0] psum_row_t;   // one word per column

    localparam phase_t phase_mbist = 2'd0;
    localparam phase_t phase_sa = 2'd1;
    localparam phase_t phase_td = 2'd2;

    typedef enum logic [4:0] {
        idle, mbist_write, mbist_read, mbist_check,
        lbist_start, sa_shift, sa_capture, sa_check,
        td_shift, td_launch, td_propagate, td_capture, td_check,
        complete, fail
    } bist_state_e;

    typedef struct packed {
        logic wr_en;
        addr_t wr_addr;
        addr_t rd_addr;
        logic test_mode;
    } acc_ctrl_t;

    typedef struct packed {
        phase_t phase;
        pat_idx_t pattern;
        pe_sel_t pe;
        addr_t addr;
    } test_step_t;

endpackage

//--- source/mbist_pattern_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mbist background generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mbist_pattern_gen (
    input  bist_pkg::pat_idx_t pattern,
    output bist_pkg::psum_t mbist_word
);

    // backgrounds are built wide and cut down to the psum width
    always_comb begin
        case (pattern[2:0])
            3'd0: mbist_word = '0;
            3'd1: mbist_word = '1;
            3'd2: mbist_word = bist_pkg::psum_t'({10{2'b01}});  // checkerboard
            3'd3: mbist_word = bist_pkg::psum_t'({10{2'b10}});
            3'd4: mbist_word = bist_pkg::psum_t'({5{4'b0011}}); // double stripes
            3'd5: mbist_word = bist_pkg::psum_t'({5{4'b1100}});
            3'd6: mbist_word = bist_pkg::psum_t'({3{8'h0f}});   // nibble stripes
            default: mbist_word = bist_pkg::psum_t'({3{8'hf0}});
        endcase
    end

endmodule

//--- source/bist_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bist sequencer
// runs mbist or sa/td lbist and drives accumulator control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bist_sequencer #(
    parameter int mbist_depth = 8,
    parameter int sa_depth = 12,
    parameter int td_depth = 18
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic test_mode,
    input  logic bist_mode,          // 0 mbist, 1 lbist
    input  logic any_mismatch,
    input  bist_pkg::psum_t envm_answer,
    input  bist_pkg::psum_t mbist_word,
    output bist_pkg::acc_ctrl_t acc_ctrl,
    output bist_pkg::psum_row_t acc_wr_data,
    output logic scan_en,
    output logic test_type,          // 0 sa, 1 td
    output logic check_en,
    output logic clear,
    output bist_pkg::test_step_t step,
    output bist_pkg::psum_t expected,
    output logic test_done,
    output logic test_pass
);

    bist_pkg::bist_state_e state, next_state;
    bist_pkg::pat_idx_t pattern;
    bist_pkg::pe_sel_t pe;
    bist_pkg::addr_t addr;
    logic run_start;
    logic last_addr;
    logic last_pe;
    logic mbist_last;
    logic sa_last;
    logic td_last;

    assign run_start = (state == bist_pkg::idle) && start && test_mode;
    assign last_addr = addr == bist_pkg::addr_t'(bist_pkg::array_size - 1);
    assign last_pe = pe == '1;
    assign mbist_last = pattern == bist_pkg::pat_idx_t'(mbist_depth - 1);
    assign sa_last = pattern == bist_pkg::pat_idx_t'(sa_depth - 1);
    assign td_last = pattern == bist_pkg::pat_idx_t'(td_depth - 1);

    assign clear = run_start;        // wipes sticky faults for the new run
    assign acc_wr_data = {bist_pkg::array_size{mbist_word}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bist_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bist_pkg::idle: begin
                if (run_start) begin
                    next_state = bist_mode ? bist_pkg::lbist_start : bist_pkg::mbist_write;
                end
            end
            bist_pkg::mbist_write: if (last_addr) next_state = bist_pkg::mbist_read;
            bist_pkg::mbist_read: next_state = bist_pkg::mbist_check;
            bist_pkg::mbist_check: begin
                if (any_mismatch) begin
                    next_state = bist_pkg::fail;
                end else if (!last_addr) begin
                    next_state = bist_pkg::mbist_read;
                end else begin
                    next_state = mbist_last ? bist_pkg::complete : bist_pkg::mbist_write;
                end
            end
            bist_pkg::lbist_start: next_state = bist_pkg::sa_shift;
            bist_pkg::sa_shift: next_state = bist_pkg::sa_capture;
            bist_pkg::sa_capture: next_state = bist_pkg::sa_check;
            bist_pkg::sa_check: begin
                if (any_mismatch) begin
                    next_state = bist_pkg::fail;
                end else begin
                    next_state = sa_last ? bist_pkg::td_shift : bist_pkg::sa_shift;
                end
            end
            bist_pkg::td_shift: next_state = bist_pkg::td_launch;
            bist_pkg::td_launch: next_state = bist_pkg::td_propagate;
            bist_pkg::td_propagate: begin
                next_state = any_mismatch ? bist_pkg::fail : bist_pkg::td_capture;
            end
            bist_pkg::td_capture: next_state = bist_pkg::td_check;
            bist_pkg::td_check: begin
                if (any_mismatch) begin
                    next_state = bist_pkg::fail;
                end else if (last_pe && td_last) begin
                    next_state = bist_pkg::complete;
                end else begin
                    next_state = bist_pkg::td_shift;
                end
            end
            bist_pkg::complete, bist_pkg::fail: begin
                if (!start) next_state = bist_pkg::idle;   // hold result until start drops
            end
            default: next_state = bist_pkg::idle;
        endcase
    end

    // counters only move on a passing check, so a fail keeps the failing step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pattern <= '0;
            pe <= '0;
            addr <= '0;
        end else if (run_start) begin
            pattern <= '0;
            pe <= '0;
            addr <= '0;
        end else begin
            case (state)
                bist_pkg::mbist_write: addr <= last_addr ? '0 : addr + 1'b1;
                bist_pkg::mbist_check: begin
                    if (!any_mismatch) begin
                        if (last_addr) begin
                            addr <= '0;
                            if (!mbist_last) pattern <= pattern + 1'b1;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end
                end
                bist_pkg::sa_check: begin
                    if (!any_mismatch) pattern <= sa_last ? '0 : pattern + 1'b1;
                end
                bist_pkg::td_check: begin
                    if (!any_mismatch) begin
                        if (last_pe) begin
                            pe <= '0;
                            if (!td_last) pattern <= pattern + 1'b1;
                        end else begin
                            pe <= pe + 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // expected word for the checkers
    always_ff @(posedge clk) begin
        case (state)
            bist_pkg::mbist_write: expected <= mbist_word;
            bist_pkg::sa_shift, bist_pkg::td_shift: expected <= envm_answer;
            default: ;
        endcase
    end

    always_comb begin
        acc_ctrl = '0;
        acc_ctrl.wr_addr = addr;
        acc_ctrl.rd_addr = addr;     // read data lands in the following check state
        scan_en = 1'b0;
        test_type = 1'b0;
        check_en = 1'b0;
        test_done = 1'b0;
        test_pass = 1'b0;
        step.phase = bist_pkg::phase_mbist;
        step.pattern = pattern;
        step.pe = pe;
        step.addr = addr;
        case (state)
            bist_pkg::mbist_write: begin
                acc_ctrl.wr_en = 1'b1;
                acc_ctrl.test_mode = 1'b1;
            end
            bist_pkg::mbist_read: acc_ctrl.test_mode = 1'b1;
            bist_pkg::mbist_check: begin
                acc_ctrl.test_mode = 1'b1;
                check_en = 1'b1;
            end
            bist_pkg::lbist_start, bist_pkg::sa_capture: begin
                acc_ctrl.test_mode = 1'b1;
                step.phase = bist_pkg::phase_sa;
            end
            bist_pkg::sa_shift: begin
                acc_ctrl.test_mode = 1'b1;
                scan_en = 1'b1;
                step.phase = bist_pkg::phase_sa;
            end
            bist_pkg::sa_check: begin
                acc_ctrl.test_mode = 1'b1;
                check_en = 1'b1;
                step.phase = bist_pkg::phase_sa;
            end
            bist_pkg::td_shift: begin
                acc_ctrl.test_mode = 1'b1;
                scan_en = 1'b1;
                test_type = 1'b1;
                step.phase = bist_pkg::phase_td;
            end
            bist_pkg::td_launch, bist_pkg::td_capture: begin
                acc_ctrl.test_mode = 1'b1;
                test_type = 1'b1;
                step.phase = bist_pkg::phase_td;
            end
            bist_pkg::td_propagate, bist_pkg::td_check: begin
                acc_ctrl.test_mode = 1'b1;
                test_type = 1'b1;
                check_en = 1'b1;     // checked at propagate and after capture
                step.phase = bist_pkg::phase_td;
            end
            bist_pkg::complete: begin
                test_done = 1'b1;
                test_pass = 1'b1;
            end
            bist_pkg::fail: test_done = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- source/column_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// column checker
// compares one column sum, keeps a sticky fault
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module column_checker (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic check_en,
    input  bist_pkg::psum_t expected,
    input  bist_pkg::psum_t column_sum,
    output logic mismatch,
    output logic fault
);

    assign mismatch = check_en && (column_sum != expected);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (clear) begin
            fault <= 1'b0;
        end else if (mismatch) begin
            fault <= 1'b1;   // stays set until the next run
        end
    end

endmodule

//--- source/fault_collector.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fault collector
// merges column results, records the first failing step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fault_collector (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic [bist_pkg::array_size-1:0] mismatch,
    input  logic [bist_pkg::array_size-1:0] fault,
    input  bist_pkg::test_step_t step,
    output logic any_mismatch,
    output logic [bist_pkg::array_size-1:0] fail_map,
    output bist_pkg::test_step_t fail_step
);

    logic captured;      // first failure already seen
    logic first_fail;

    assign any_mismatch = |mismatch;
    assign fail_map = fault;
    assign first_fail = any_mismatch && !captured;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            captured <= 1'b0;
        end else if (clear) begin
            captured <= 1'b0;
        end else if (first_fail) begin
            captured <= 1'b1;
        end
    end

    // step is still the one under check here
    always_ff @(posedge clk) begin
        if (first_fail) begin
            fail_step <= step;
        end
    end

endmodule

//--- source/hybrid_bist_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hybrid bist top
// mbist and lbist control for the systolic array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bist_defs.svh"

module hybrid_bist_top #(
    parameter int mbist_depth = `bist_mbist_depth,
    parameter int sa_depth = `bist_sa_depth,
    parameter int td_depth = `bist_td_depth
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic test_mode,
    input  logic bist_mode,
    input  bist_pkg::psum_t envm_answer,
    input  bist_pkg::psum_row_t partial_sum,
    output bist_pkg::acc_ctrl_t acc_ctrl,
    output bist_pkg::psum_row_t acc_wr_data,
    output logic scan_en,
    output logic test_type,
    output bist_pkg::test_step_t step,
    output logic test_done,
    output logic test_pass,
    output logic [bist_pkg::array_size-1:0] fail_map,
    output bist_pkg::test_step_t fail_step
);

    bist_pkg::psum_t mbist_word;
    bist_pkg::psum_t expected;
    logic check_en;
    logic clear;
    logic any_mismatch;
    logic [bist_pkg::array_size-1:0] mismatch;
    logic [bist_pkg::array_size-1:0] fault;

    bist_sequencer #(
        .mbist_depth(mbist_depth),
        .sa_depth(sa_depth),
        .td_depth(td_depth)
    ) u_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .test_mode(test_mode),
        .bist_mode(bist_mode),
        .any_mismatch(any_mismatch),
        .envm_answer(envm_answer),
        .mbist_word(mbist_word),
        .acc_ctrl(acc_ctrl),
        .acc_wr_data(acc_wr_data),
        .scan_en(scan_en),
        .test_type(test_type),
        .check_en(check_en),
        .clear(clear),
        .step(step),
        .expected(expected),
        .test_done(test_done),
        .test_pass(test_pass)
    );

    mbist_pattern_gen u_pattern_gen (
        .pattern(step.pattern),
        .mbist_word(mbist_word)
    );

    // one checker per array column
    for (genvar col = 0; col < bist_pkg::array_size; col++) begin : g_col
        column_checker u_checker (
            .clk(clk),
            .rst_n(rst_n),
            .clear(clear),
            .check_en(check_en),
            .expected(expected),
            .column_sum(partial_sum[col]),
            .mismatch(mismatch[col]),
            .fault(fault[col])
        );
    end

    fault_collector u_collector (
        .clk(clk),
        .rst_n(rst_n),
        .clear(clear),
        .mismatch(mismatch),
        .fault(fault),
        .step(step),
        .any_mismatch(any_mismatch),
        .fail_map(fail_map),
        .fail_step(fail_step)
    );

endmodule

//--- tests/array_stub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// array stub
// accumulator, systolic array and envm model with fault injection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module array_stub (
    input  logic clk,
    input  bist_pkg::acc_ctrl_t acc_ctrl,
    input  bist_pkg::psum_row_t acc_wr_data,
    input  logic scan_en,
    input  bist_pkg::test_step_t step,
    input  logic fault_on,
    input  logic fault_any,              // every read, else only at fault_at
    input  int fault_col,
    input  bist_pkg::test_step_t fault_at,
    output bist_pkg::psum_t envm_answer,
    output bist_pkg::psum_row_t partial_sum
);

    timeunit 1ns;
    timeprecision 100ps;

    // envm tables, filled by the testbench
    bist_pkg::weight_t weight_mem [2**bist_pkg::pat_w][2**bist_pkg::pe_w];
    bist_pkg::act_t act_mem [2**bist_pkg::pat_w][2**bist_pkg::pe_w];
    bist_pkg::psum_row_t acc_mem [bist_pkg::array_size];
    bist_pkg::psum_row_t read_row;
    logic fault_hit;

    assign envm_answer = bist_pkg::psum_t'(weight_mem[step.pattern][step.pe])
                       * bist_pkg::psum_t'(act_mem[step.pattern][step.pe]);

    assign fault_hit = fault_on && (fault_any || (step.phase == fault_at.phase
                       && step.pattern == fault_at.pattern && step.pe == fault_at.pe));

    always_ff @(posedge clk) begin
        if (acc_ctrl.wr_en) begin
            acc_mem[acc_ctrl.wr_addr] <= acc_wr_data;
        end
    end

    always_comb begin
        if (step.phase == bist_pkg::phase_mbist) begin
            read_row = acc_mem[acc_ctrl.rd_addr];
        end else if (scan_en) begin
            read_row = '0;                   // chain moving, no valid sum
        end else begin
            read_row = {bist_pkg::array_size{envm_answer}};  // same product on every column
        end
        if (fault_hit) begin
            read_row[fault_col][0] = ~read_row[fault_col][0];
        end
    end

    always_ff @(posedge clk) begin
        partial_sum <= read_row;             // one cycle read latency
    end

endmodule

//--- tests/tb_hybrid_bist.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hybrid bist testbench
// random mbist and lbist runs against a cycle model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bist_defs.svh"

module tb_hybrid_bist;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mbist_depth = `bist_mbist_depth;
    localparam int sa_depth = `bist_sa_depth;
    localparam int td_depth = `bist_td_depth;
    localparam int clk_period = 10;
    localparam int run_limit = 600;                  // cycles allowed for one run
    localparam int watchdog_cycles = 6 * run_limit;
    localparam int mbist_pat_len = 3 * bist_pkg::array_size;    // writes, then read/check pairs
    localparam int mbist_cycles = 1 + mbist_depth * mbist_pat_len;
    localparam int sa_end = 1 + 3 * sa_depth;       // last sa cycle of a run
    localparam int lbist_cycles = sa_end + 1 + td_depth * 4 * 5;

    logic clk, rst_n, start, test_mode, bist_mode;
    logic scan_en, test_type, test_done, test_pass;
    logic [bist_pkg::array_size-1:0] fail_map;
    bist_pkg::psum_t envm_answer;
    bist_pkg::psum_row_t partial_sum, acc_wr_data;
    bist_pkg::acc_ctrl_t acc_ctrl;
    bist_pkg::test_step_t step, fail_step, fault_at;
    logic fault_on, fault_any;
    int fault_col;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_base = 0;
    int unsigned rng_state = 55;

    hybrid_bist_top #(
        .mbist_depth(mbist_depth),
        .sa_depth(sa_depth),
        .td_depth(td_depth)
    ) i_hybrid_bist_top (
        .clk(clk), .rst_n(rst_n), .start(start), .test_mode(test_mode),
        .bist_mode(bist_mode), .envm_answer(envm_answer), .partial_sum(partial_sum),
        .acc_ctrl(acc_ctrl), .acc_wr_data(acc_wr_data), .scan_en(scan_en),
        .test_type(test_type), .step(step), .test_done(test_done),
        .test_pass(test_pass), .fail_map(fail_map), .fail_step(fail_step)
    );

    array_stub i_array_stub (
        .clk(clk), .acc_ctrl(acc_ctrl), .acc_wr_data(acc_wr_data), .scan_en(scan_en),
        .step(step), .fault_on(fault_on), .fault_any(fault_any), .fault_col(fault_col),
        .fault_at(fault_at), .envm_answer(envm_answer), .partial_sum(partial_sum)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    function automatic int unsigned xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // 0 and 1 are solid, then stripes of 1, 2 and 4 bits, odd index inverted
    function automatic bist_pkg::psum_t background(input int p);
        bist_pkg::psum_t w;
        int k;
        k = p / 2 - 1;
        for (int i = 0; i < bist_pkg::psum_w; i++) begin
            if (p < 2) w[i] = p[0];
            else w[i] = ((i >> k) & 1) == (p % 2);
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err_base) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_err_base = errors;
    endtask

    task automatic expect_idle();
        check_value("scan_en", scan_en, 0);
        check_value("acc_ctrl.wr_en", acc_ctrl.wr_en, 0);
        check_value("acc_ctrl.test_mode", acc_ctrl.test_mode, 0);
        check_value("check_en", i_hybrid_bist_top.check_en, 0);
        check_value("test_done", test_done, 0);
        check_value("test_pass", test_pass, 0);
    endtask

    // expected controls in cycle n of a run, n = 1 right after start is taken
    task automatic check_cycle(input logic mode, input int n);
        int o;
        int m;
        bist_pkg::test_step_t s;
        s = '0;
        check_value("acc_ctrl.test_mode", acc_ctrl.test_mode, 1);
        if (!mode) begin
            o = (n - 1) % mbist_pat_len;
            s.phase = bist_pkg::phase_mbist;
            s.pattern = bist_pkg::pat_idx_t'((n - 1) / mbist_pat_len);
            check_value("acc_ctrl.wr_en", acc_ctrl.wr_en, o < bist_pkg::array_size);
            if (o < bist_pkg::array_size) begin
                s.addr = bist_pkg::addr_t'(o);
                check_value("acc_ctrl.wr_addr", acc_ctrl.wr_addr, o);
                for (int c = 0; c < bist_pkg::array_size; c++) begin
                    check_value($sformatf("acc_wr_data[%0d]", c), acc_wr_data[c],
                                background((n - 1) / mbist_pat_len));
                end
            end else begin
                s.addr = bist_pkg::addr_t'((o - bist_pkg::array_size) / 2);
                check_value("acc_ctrl.rd_addr", acc_ctrl.rd_addr,
                            (o - bist_pkg::array_size) / 2);
            end
            check_value("scan_en", scan_en, 0);
            check_value("test_type", test_type, 0);
        end else begin
            check_value("acc_ctrl.wr_en", acc_ctrl.wr_en, 0);
            if (n <= sa_end) begin
                s.phase = bist_pkg::phase_sa;
                if (n > 1) s.pattern = bist_pkg::pat_idx_t'((n - 2) / 3);
                check_value("scan_en", scan_en, n > 1 && (n - 2) % 3 == 0);
                check_value("test_type", test_type, 0);
            end else begin
                m = n - sa_end - 1;              // cycle within the td phase
                s.phase = bist_pkg::phase_td;
                s.pattern = bist_pkg::pat_idx_t'(m / (4 * 5));  // 4 pe slots of 5 cycles
                s.pe = bist_pkg::pe_sel_t'((m / 5) % 4);
                check_value("scan_en", scan_en, m % 5 == 0);
                check_value("test_type", test_type, 1);
            end
        end
        check_value("step", step, s);
    endtask

    // exp_cycles of 0 skips the length check
    task automatic run_bist(input logic mode, input int exp_cycles);
        int n;
        n = 0;
        @(posedge clk);
        start <= 1'b1;
        test_mode <= 1'b1;
        bist_mode <= mode;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (!test_done) check_cycle(mode, n);
        end while (!test_done && n < run_limit);
        if (!test_done) begin
            errors++;
            $display("run did not finish within %0d cycles", run_limit);
        end else if (exp_cycles > 0) begin
            check_value("run cycles", n, exp_cycles);
        end
    endtask

    task automatic finish_run();
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);                      // start seen low, back to idle
        @(negedge clk);
        expect_idle();
    endtask

    task automatic arm_fault(input logic on, input logic any, input int col,
                             input bist_pkg::test_step_t at);
        @(posedge clk);
        fault_on <= on;
        fault_any <= any;
        fault_col <= col;
        fault_at <= at;
    endtask

    task automatic check_failure(input int col, input bist_pkg::test_step_t exp_step);
        check_value("test_pass", test_pass, 0);
        check_value("fail_map", fail_map, 1 << col);
        check_value("fail_step", fail_step, exp_step);
    endtask

    initial begin
        logic [31:0] rnd;
        int col;
        bist_pkg::test_step_t at;
        rst_n = 1'b0;
        start = 1'b0;
        test_mode = 1'b0;
        bist_mode = 1'b0;
        fault_on = 1'b0;
        fault_any = 1'b0;
        fault_col = 0;
        fault_at = '0;
        for (int p = 0; p < 2**bist_pkg::pat_w; p++) begin
            for (int e = 0; e < 2**bist_pkg::pe_w; e++) begin
                rnd = xorshift();
                i_array_stub.weight_mem[p][e] = rnd[7:0];
                i_array_stub.act_mem[p][e] = rnd[15:8];
            end
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_idle();
        check_value("fail_map", fail_map, 0);
        end_test("reset state");

        run_bist(1'b0, mbist_cycles);
        check_value("test_pass", test_pass, 1);
        check_value("fail_map", fail_map, 0);
        finish_run();
        end_test("clean mbist");

        col = xorshift() % bist_pkg::array_size;
        arm_fault(1'b1, 1'b1, col, '0);      // stuck bit on every read of that column
        run_bist(1'b0, 0);
        at = '0;
        at.phase = bist_pkg::phase_mbist;
        check_failure(col, at);
        finish_run();
        end_test("mbist stuck column");

        arm_fault(1'b0, 1'b0, 0, '0);
        run_bist(1'b1, lbist_cycles);
        check_value("test_pass", test_pass, 1);
        check_value("fail_map", fail_map, 0);
        finish_run();
        end_test("clean lbist");

        at = '0;
        at.phase = bist_pkg::phase_sa;
        at.pattern = xorshift() % sa_depth;
        col = xorshift() % bist_pkg::array_size;
        arm_fault(1'b1, 1'b0, col, at);
        run_bist(1'b1, 0);
        check_failure(col, at);
        finish_run();
        end_test("sa fault");

        at = '0;
        at.phase = bist_pkg::phase_td;
        at.pattern = xorshift() % td_depth;
        at.pe = xorshift() % 4;
        col = xorshift() % bist_pkg::array_size;
        arm_fault(1'b1, 1'b0, col, at);
        run_bist(1'b1, 0);
        check_failure(col, at);
        finish_run();
        end_test("td fault");

        // fail_map still set from the td run, the new run must clear it
        arm_fault(1'b0, 1'b0, 0, '0);
        run_bist(1'b0, mbist_cycles);
        check_value("test_pass", test_pass, 1);
        check_value("fail_map", fail_map, 0);
        finish_run();
        @(posedge clk);
        start <= 1'b1;
        bist_mode <= 1'b1;
        repeat (20) @(posedge clk);
        rst_n <= 1'b0;                       // reset in the middle of an lbist run
        start <= 1'b0;
        @(negedge clk);
        expect_idle();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_idle();
        end_test("reset and restart");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
source/bist_pkg.sv
source/mbist_pattern_gen.sv
source/bist_sequencer.sv
source/column_checker.sv
source/fault_collector.sv
source/hybrid_bist_top.sv
tests/array_stub.sv
tests/tb_hybrid_bist.sv
